//--- design/spi_bus_arbiter.sv
// Round-robin arbiter for two SPI clients
`timescale 1ns/1ns

module spi_bus_arbiter
    import spi_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_a,
    input  logic                  start_b,
    input  op_mode_e              op_mode_a,
    input  op_mode_e              op_mode_b,
    input  logic [SPI_MODE_W-1:0] spi_mode_a,
    input  logic [SPI_MODE_W-1:0] spi_mode_b,
    input  logic [DATA_WIDTH-1:0] tx_data_a,
    input  logic [DATA_WIDTH-1:0] tx_data_b,
    output logic                  busy_a,
    output logic                  busy_b,
    output logic                  done_a,
    output logic                  done_b,
    output logic                  m_start,    // one cycle grant strobe
    output op_mode_e              m_op_mode,
    output logic [SPI_MODE_W-1:0] m_spi_mode,
    output logic [DATA_WIDTH-1:0] m_tx_data,
    input  logic                  m_done
);

    // client a at index 0, b at index 1
    logic [1:0]            req_start;
    op_mode_e              req_op   [2];
    logic [SPI_MODE_W-1:0] req_mode [2];
    logic [DATA_WIDTH-1:0] req_data [2];
    op_mode_e              hold_op  [2]; // one queued request per client
    logic [SPI_MODE_W-1:0] hold_mode[2];
    logic [DATA_WIDTH-1:0] hold_data[2];
    logic [1:0]            pend;
    logic [1:0]            busy_v;
    logic                  active;       // master owned by a transfer
    logic                  owner;        // also the last served client
    logic                  pick;
    logic                  grant;
    logic                  sel;

    assign req_start = {start_b, start_a};
    assign req_op[0]   = op_mode_a;
    assign req_op[1]   = op_mode_b;
    assign req_mode[0] = spi_mode_a;
    assign req_mode[1] = spi_mode_b;
    assign req_data[0] = tx_data_a;
    assign req_data[1] = tx_data_b;

    assign busy_v[0] = pend[0] | (active & ~owner);
    assign busy_v[1] = pend[1] | (active & owner);
    assign busy_a    = busy_v[0];
    assign busy_b    = busy_v[1];
    assign done_a    = m_done & ~owner;  // steer to owner
    assign done_b    = m_done & owner;

    // tie goes to the client not served last
    assign pick  = (pend == 2'b11) ? ~owner : pend[1];
    assign grant = ~active & (|pend);
    // show the next request already in the decision cycle so sclk parks early
    assign sel   = active ? owner : pick;

    assign m_op_mode  = hold_op[sel];
    assign m_spi_mode = hold_mode[sel];
    assign m_tx_data  = hold_data[sel];

    // request capture, starts while busy are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2; i++) begin
                hold_op[i]   <= OP_SEND;
                hold_mode[i] <= '0; // parked sclk low out of reset
                hold_data[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (req_start[i] && !busy_v[i]) begin
                    hold_op[i]   <= req_op[i];
                    hold_mode[i] <= req_mode[i];
                    hold_data[i] <= req_data[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend    <= '0;
            active  <= 1'b0;
            owner   <= 1'b1; // client a wins the first tie
            m_start <= 1'b0;
        end else begin
            m_start <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                if (req_start[i] && !busy_v[i]) begin
                    pend[i] <= 1'b1;
                end
            end
            if (grant) begin
                pend[pick] <= 1'b0; // picked client is busy, no new start collides
                owner      <= pick;
                active     <= 1'b1;
                m_start    <= 1'b1;
            end else if (m_done) begin
                active <= 1'b0;
            end
        end
    end

endmodule

//--- design/spi_clock_gen.sv
// SPI clock divider and edge strobes
`timescale 1ns/1ns

module spi_clock_gen
    import spi_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,     // high for the whole transfer
    input  logic                 cpol,       // idle level of sclk
    input  logic                 cpha,
    input  logic [CLK_DIV_W-1:0] clk_div,    // half period in clk cycles
    output logic                 sclk,
    output logic                 change_stb, // mosi moves at this toggle
    output logic                 sample_stb  // miso captured at this toggle
);

    logic [CLK_DIV_W-1:0] cnt;          // half period counter
    logic                 first;        // no toggle yet in this transfer
    logic                 half_done;    // sclk toggles at the coming edge
    logic                 leading;      // toggle leaves the idle level
    logic                 lead_samples; // modes 0 and 3
    logic                 is_sample;

    // clk_div of 0 behaves like 1
    assign half_done    = enable && (({1'b0, cnt} + 1'b1) >= {1'b0, clk_div});
    assign leading      = (sclk == cpol);
    assign lead_samples = (cpol == cpha);
    assign is_sample    = ~(leading ^ lead_samples);

    // strobes line up with the edge where sclk toggles
    assign sample_stb = half_done & is_sample;
    // a change as the very first toggle is dropped, the msb is already on mosi
    assign change_stb = half_done & ~is_sample & ~first;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            sclk  <= 1'b0; // cpol of reset mode
            first <= 1'b1;
        end else if (!enable) begin
            cnt   <= '0;   // park at idle level
            sclk  <= cpol;
            first <= 1'b1;
        end else if (half_done) begin
            cnt   <= '0;
            sclk  <= ~sclk;
            first <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- design/spi_master.sv
// SPI master transfer engine
`timescale 1ns/1ns

module spi_master
    import spi_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,    // only seen in idle
    input  op_mode_e              op_mode,
    input  logic [SPI_MODE_W-1:0] spi_mode,
    input  logic [CLK_DIV_W-1:0]  clk_div,
    input  logic [DATA_WIDTH-1:0] tx_data,
    output logic [DATA_WIDTH-1:0] rx_data,
    output logic                  done,     // one cycle, with cs rising
    output logic                  spi_clk,
    output logic                  spi_mosi,
    output logic                  spi_cs,
    input  logic                  spi_miso
);

    // counter must reach DATA_WIDTH itself
    localparam int CNT_W = $clog2(DATA_WIDTH + 1);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(DATA_WIDTH);

    typedef enum logic {
        ST_IDLE,
        ST_XFER
    } state_e;

    state_e                state;
    op_mode_e              op_q;         // latched at start
    logic [SPI_MODE_W-1:0] mode_q;       // latched at start
    logic [SPI_MODE_W-1:0] mode_cur;     // mode seen by the divider
    logic [DATA_WIDTH-1:0] tx_sh;        // msb drives mosi
    logic [DATA_WIDTH-1:0] rx_sh;        // miso enters at lsb
    logic [CNT_W-1:0]      bit_cnt;      // sample strobes so far
    logic                  active;
    logic                  change_stb;
    logic                  sample_stb;
    logic                  trail_sample; // modes 1 and 2 sample on trailing edge
    logic                  last_bit;

    // in idle the incoming mode sets the parked sclk level
    assign mode_cur     = (state == ST_IDLE) ? spi_mode : mode_q;
    assign active       = (state == ST_XFER);
    assign trail_sample = mode_q[0] ^ mode_q[1];
    assign last_bit     = (bit_cnt == BIT_END - 1'b1);

    assign spi_mosi = tx_sh[DATA_WIDTH-1];
    assign rx_data  = rx_sh;

    spi_clock_gen i_clock_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (active),
        .cpol       (mode_cur[0]),
        .cpha       (mode_cur[1]),
        .clk_div    (clk_div),
        .sclk       (spi_clk),
        .change_stb (change_stb),
        .sample_stb (sample_stb)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            spi_cs  <= 1'b1;
            done    <= 1'b0;
            op_q    <= OP_SEND;
            mode_q  <= '0;
            bit_cnt <= '0;
            tx_sh   <= '0;
            rx_sh   <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        spi_cs  <= 1'b0;
                        op_q    <= op_mode;
                        mode_q  <= spi_mode;
                        bit_cnt <= '0;
                        tx_sh   <= op_has_tx(op_mode) ? tx_data : '0; // zeros keep mosi low
                        rx_sh   <= '0;
                        state   <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    if (sample_stb) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (op_has_rx(op_q)) begin
                            rx_sh <= {rx_sh[DATA_WIDTH-2:0], spi_miso}; // msb first
                        end
                        if (trail_sample && last_bit) begin // last sample closes the word
                            spi_cs <= 1'b1;
                            done   <= 1'b1;
                            state  <= ST_IDLE;
                        end
                    end else if (change_stb) begin
                        if (bit_cnt == BIT_END) begin // trailing edge after last sample
                            spi_cs <= 1'b1;
                            done   <= 1'b1;
                            state  <= ST_IDLE;
                        end else if (op_has_tx(op_q)) begin
                            tx_sh <= {tx_sh[DATA_WIDTH-2:0], 1'b0};
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- design/spi_pkg.sv
// SPI subsystem shared definitions
package spi_pkg;

    localparam int SPI_MODE_W = 2;  // bit 0 cpol, bit 1 cpha
    localparam int CLK_DIV_W  = 16; // system clocks per spi half period

    // operation mode of one transfer
    typedef enum logic [1:0] {
        OP_SEND = 2'd0, // mosi only, rx reads zero
        OP_RECV = 2'd1, // miso only, mosi held low
        OP_BOTH = 2'd2  // full duplex
    } op_mode_e;

    // code 3 falls through to full duplex in both helpers
    function automatic logic op_has_tx(op_mode_e op);
        return op != OP_RECV;
    endfunction

    function automatic logic op_has_rx(op_mode_e op);
        return op != OP_SEND;
    endfunction

endpackage

//--- design/spi_subsystem.sv
// Two-client SPI master subsystem
`timescale 1ns/1ns

module spi_subsystem
    import spi_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [CLK_DIV_W-1:0]  clk_div,    // static during a transfer
    input  logic                  start_a,
    input  logic                  start_b,
    input  op_mode_e              op_mode_a,
    input  op_mode_e              op_mode_b,
    input  logic [SPI_MODE_W-1:0] spi_mode_a,
    input  logic [SPI_MODE_W-1:0] spi_mode_b,
    input  logic [DATA_WIDTH-1:0] tx_data_a,
    input  logic [DATA_WIDTH-1:0] tx_data_b,
    output logic                  busy_a,
    output logic                  busy_b,
    output logic                  done_a,
    output logic                  done_b,
    output logic [DATA_WIDTH-1:0] rx_data,    // shared by both clients
    output logic                  spi_clk,
    output logic                  spi_mosi,
    output logic                  spi_cs,
    input  logic                  spi_miso
);

    logic                  m_start;
    op_mode_e              m_op_mode;
    logic [SPI_MODE_W-1:0] m_spi_mode;
    logic [DATA_WIDTH-1:0] m_tx_data;
    logic                  m_done;

    spi_bus_arbiter #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_a    (start_a),
        .start_b    (start_b),
        .op_mode_a  (op_mode_a),
        .op_mode_b  (op_mode_b),
        .spi_mode_a (spi_mode_a),
        .spi_mode_b (spi_mode_b),
        .tx_data_a  (tx_data_a),
        .tx_data_b  (tx_data_b),
        .busy_a     (busy_a),
        .busy_b     (busy_b),
        .done_a     (done_a),
        .done_b     (done_b),
        .m_start    (m_start),
        .m_op_mode  (m_op_mode),
        .m_spi_mode (m_spi_mode),
        .m_tx_data  (m_tx_data),
        .m_done     (m_done)
    );

    spi_master #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_master (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (m_start),
        .op_mode  (m_op_mode),
        .spi_mode (m_spi_mode),
        .clk_div  (clk_div),
        .tx_data  (m_tx_data),
        .rx_data  (rx_data), // held until next start
        .done     (m_done),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_cs   (spi_cs),
        .spi_miso (spi_miso)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the SPI subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_spi_subsystem -o sim_tb \
    && ./obj_dir/sim_tb > sim.log
cat sim.log 2>/dev/null
grep -qx '>>> PASS' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- sources.f
design/spi_pkg.sv
design/spi_clock_gen.sv
design/spi_master.sv
design/spi_bus_arbiter.sv
design/spi_subsystem.sv
test/spi_slave_model.sv
test/tb_spi_subsystem.sv

//--- test/spi_golden.txt
// client op_mode spi_mode clk_div tx_data reply exp_rx exp_mosi (hex)
// client 0 is a, 1 is b, 2 is a started together with b on the next line
0 2 0 2 a5 3c 3c a5
1 2 1 2 96 c3 c3 96
0 2 2 3 5a 81 81 5a
1 2 3 3 e7 18 18 e7
0 0 0 2 d2 ff 00 d2
1 1 3 2 77 6b 6b 00
2 2 0 2 11 22 22 11
1 2 0 2 33 44 44 33
0 3 1 1 0f f0 f0 0f
2 2 1 2 55 66 66 55
1 2 2 2 9a bc bc 9a

//--- test/spi_slave_model.sv
// Behavioral SPI slave
`timescale 1ns/1ns

module spi_slave_model #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  spi_clk,
    input  logic                  spi_mosi,
    input  logic                  spi_cs,
    output logic                  spi_miso,
    input  logic                  cpha,      // 0 samples on rising sclk
    input  logic [DATA_WIDTH-1:0] reply,     // taken at cs falling
    output logic [DATA_WIDTH-1:0] mosi_word  // msb first capture
);

    logic [DATA_WIDTH-1:0] reply_sh = '0;
    logic                  cs_q     = 1'b1;
    logic                  sclk_q   = 1'b0;
    int                    bits     = DATA_WIDTH; // full count ignores idle sclk moves

    assign spi_miso = reply_sh[DATA_WIDTH-1];

    initial mosi_word = '0;

    always @(spi_clk or spi_cs) begin
        if (spi_cs !== cs_q) begin
            cs_q = spi_cs;
            if (spi_cs === 1'b0) begin // new word
                reply_sh  = reply;
                mosi_word = '0;
                bits      = 0;
            end
        end
        if (spi_clk !== sclk_q) begin
            sclk_q = spi_clk;
            if (bits < DATA_WIDTH) begin
                if (spi_clk != cpha) begin // sample edge
                    mosi_word = {mosi_word[DATA_WIDTH-2:0], spi_mosi};
                    bits++;
                end else if (bits > 0) begin // change edge after a sample
                    reply_sh = {reply_sh[DATA_WIDTH-2:0], 1'b0};
                end
            end
        end
    end

endmodule

//--- test/tb_spi_subsystem.sv
// SPI subsystem testbench
`timescale 1ns/1ns

module tb_spi_subsystem;
    import spi_pkg::*;

    localparam int          DATA_WIDTH  = 8;
    localparam int          NUM_LINES   = 11;
    localparam int          FIELDS      = 8;
    localparam int          COL_CLIENT  = 0;
    localparam int          COL_OP      = 1;
    localparam int          COL_MODE    = 2;
    localparam int          COL_DIV     = 3;
    localparam int          COL_TX      = 4;
    localparam int          COL_REPLY   = 5;
    localparam int          COL_RX      = 6;
    localparam int          COL_MOSI    = 7;
    localparam int          TIMEOUT     = 5000; // clk cycles per wait
    localparam int          QUIET       = 200;  // window for stray done pulses
    localparam logic [31:0] SEED        = 32'h6724;
    localparam string       GOLDEN_FILE = "test/spi_golden.txt";

    logic                  clk;
    logic                  rst_n;
    logic [CLK_DIV_W-1:0]  clk_div;
    logic                  start_a;
    logic                  start_b;
    op_mode_e              op_mode_a;
    op_mode_e              op_mode_b;
    logic [SPI_MODE_W-1:0] spi_mode_a;
    logic [SPI_MODE_W-1:0] spi_mode_b;
    logic [DATA_WIDTH-1:0] tx_data_a;
    logic [DATA_WIDTH-1:0] tx_data_b;
    logic                  busy_a;
    logic                  busy_b;
    logic                  done_a;
    logic                  done_b;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  spi_clk;
    logic                  spi_mosi;
    logic                  spi_cs;
    logic                  spi_miso;
    logic                  slave_cpha;
    logic [DATA_WIDTH-1:0] slave_reply;
    logic [DATA_WIDTH-1:0] slave_word;

    logic [15:0] golden [NUM_LINES*FIELDS];
    int          errors;
    int          timeouts;
    int          cs_low_cycles; // cleared before each transfer
    int          done_cnt_a;
    int          done_cnt_b;
    int          exp_done_a;
    int          exp_done_b;
    logic        last_served;   // 1 is client b, as after reset
    int          line;

    spi_subsystem #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .clk_div    (clk_div),
        .start_a    (start_a),
        .start_b    (start_b),
        .op_mode_a  (op_mode_a),
        .op_mode_b  (op_mode_b),
        .spi_mode_a (spi_mode_a),
        .spi_mode_b (spi_mode_b),
        .tx_data_a  (tx_data_a),
        .tx_data_b  (tx_data_b),
        .busy_a     (busy_a),
        .busy_b     (busy_b),
        .done_a     (done_a),
        .done_b     (done_b),
        .rx_data    (rx_data),
        .spi_clk    (spi_clk),
        .spi_mosi   (spi_mosi),
        .spi_cs     (spi_cs),
        .spi_miso   (spi_miso)
    );

    spi_slave_model #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_slave (
        .spi_clk   (spi_clk),
        .spi_mosi  (spi_mosi),
        .spi_cs    (spi_cs),
        .spi_miso  (spi_miso),
        .cpha      (slave_cpha),
        .reply     (slave_reply),
        .mosi_word (slave_word)
    );

    always #50 clk = ~clk;

    always @(negedge clk) begin // mid-cycle, outputs settled
        if (spi_cs === 1'b0) cs_low_cycles++;
        if (done_a === 1'b1) done_cnt_a++;
        if (done_b === 1'b1) done_cnt_b++;
    end

    function automatic logic client_of(int ln);
        return golden[ln*FIELDS + COL_CLIENT] == 16'd1; // code 2 is client a
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic next_drive_slot();
        @(posedge clk);
        #10;
    endtask

    task automatic wait_idle(output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < TIMEOUT) begin
            @(negedge clk);
            ok = !busy_a && !busy_b;
            n++;
        end
        if (!ok) begin
            timeouts++;
            $display("timeout: busy did not fall within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic wait_done(output logic [1:0] got, output logic ok);
        int n;
        n   = 0;
        ok  = 1'b0;
        got = 2'b00;
        while (!ok && n < TIMEOUT) begin
            @(negedge clk);
            got = {done_b, done_a};
            ok  = |got;
            n++;
        end
        if (!ok) begin
            timeouts++;
            $display("timeout: no done pulse within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic prime_slave(int ln);
        slave_cpha  = golden[ln*FIELDS + COL_MODE][1];
        slave_reply = golden[ln*FIELDS + COL_REPLY][DATA_WIDTH-1:0];
        cs_low_cycles = 0;
    endtask

    task automatic set_request(int ln);
        int b;
        b = ln * FIELDS;
        if (client_of(ln)) begin
            op_mode_b  = op_mode_e'(golden[b+COL_OP][1:0]);
            spi_mode_b = golden[b+COL_MODE][SPI_MODE_W-1:0];
            tx_data_b  = golden[b+COL_TX][DATA_WIDTH-1:0];
        end else begin
            op_mode_a  = op_mode_e'(golden[b+COL_OP][1:0]);
            spi_mode_a = golden[b+COL_MODE][SPI_MODE_W-1:0];
            tx_data_a  = golden[b+COL_TX][DATA_WIDTH-1:0];
        end
    endtask

    task automatic check_result(int ln, logic [1:0] got_done);
        int         b;
        logic [1:0] exp_done;
        b        = ln * FIELDS;
        exp_done = client_of(ln) ? 2'b10 : 2'b01;
        check_value("{done_b,done_a}", 32'(got_done), 32'(exp_done));
        check_value("rx_data", 32'(rx_data), 32'(golden[b+COL_RX]));
        check_value("slave_word", 32'(slave_word), 32'(golden[b+COL_MOSI]));
        check_value("spi_cs low cycles", 32'(cs_low_cycles),
                    32'(2 * golden[b+COL_DIV] * DATA_WIDTH)); // two halves per bit
    endtask

    task automatic start_transfer(int ln, logic both);
        logic ok;
        wait_idle(ok);
        if (ok) begin
            repeat ($urandom % 4) next_drive_slot(); // random idle gap
            next_drive_slot();
            clk_div = golden[ln*FIELDS + COL_DIV];
            set_request(ln);
            if (both) set_request(ln + 1);
            start_a = both || !client_of(ln);
            start_b = both || client_of(ln);
            next_drive_slot();
            start_a = 1'b0;
            start_b = 1'b0;
            @(negedge clk); // busy follows an accepted start by one cycle
            check_value("{busy_b,busy_a}", 32'({busy_b, busy_a}),
                        both ? 32'h3 : (client_of(ln) ? 32'h2 : 32'h1));
        end
    endtask

    task automatic run_single(int ln);
        logic [1:0] got;
        logic       ok;
        prime_slave(ln);
        start_transfer(ln, 1'b0);
        if (timeouts == 0) begin
            wait_done(got, ok);
            if (ok) check_result(ln, got);
            last_served = client_of(ln);
            if (client_of(ln)) exp_done_b++;
            else exp_done_a++;
        end
    endtask

    task automatic run_pair(int ln);
        logic [1:0] got;
        logic       ok;
        int         first_ln;
        int         second_ln;
        first_ln  = last_served ? ln : ln + 1; // client not served last goes first
        second_ln = last_served ? ln + 1 : ln;
        prime_slave(first_ln);
        start_transfer(ln, 1'b1);
        if (timeouts == 0) begin
            next_drive_slot();
            tx_data_a = ~tx_data_a; // start while busy, must be dropped
            start_a   = 1'b1;
            next_drive_slot();
            start_a   = 1'b0;
            wait_done(got, ok);
            if (ok) begin
                check_result(first_ln, got);
                prime_slave(second_ln);
                wait_done(got, ok);
                if (ok) check_result(second_ln, got);
            end
            last_served = client_of(second_ln);
            exp_done_a++;
            exp_done_b++;
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        clk_div     = 16'd2;
        start_a     = 1'b0;
        start_b     = 1'b0;
        op_mode_a   = OP_BOTH;
        op_mode_b   = OP_BOTH;
        spi_mode_a  = '0;
        spi_mode_b  = '0;
        tx_data_a   = '0;
        tx_data_b   = '0;
        slave_cpha  = 1'b0;
        slave_reply = '0;
        errors      = 0;
        timeouts    = 0;
        done_cnt_a  = 0;
        done_cnt_b  = 0;
        exp_done_a  = 0;
        exp_done_b  = 0;
        last_served = 1'b1; // arbiter owner out of reset
        void'($urandom(SEED));
        $readmemh(GOLDEN_FILE, golden);
        assert (golden[NUM_LINES*FIELDS-1] !== 'x) else begin
            errors++;
            $display("golden file is missing or shorter than expected");
        end

        repeat (16) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk); // state after reset, no start yet
        check_value("spi_cs", 32'(spi_cs), 32'h1);
        check_value("spi_clk", 32'(spi_clk), 32'h0);
        check_value("{done_b,done_a}", 32'({done_b, done_a}), 32'h0);
        check_value("{busy_b,busy_a}", 32'({busy_b, busy_a}), 32'h0);

        line = 0;
        while (line < NUM_LINES && timeouts == 0) begin
            if (golden[line*FIELDS + COL_CLIENT] == 16'd2) begin // a and b together
                run_pair(line);
                line += 2;
            end else begin
                run_single(line);
                line += 1;
            end
        end

        if (timeouts == 0) begin
            repeat (QUIET) @(negedge clk); // a dropped start never yields done
            check_value("done_a count", 32'(done_cnt_a), 32'(exp_done_a));
            check_value("done_b count", 32'(done_cnt_b), 32'(exp_done_b));
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
